/* hw/mm_pkg.sv */
// sizes, vector types and the DMA state encoding for the matrix-multiply accelerator
// matrix size is fixed at N; one buffer row must equal one AXI data beat
// (N * ELEM_W == AXI_DW) since R beats land in the buffers unchanged
`default_nettype none

package mm_pkg;

    // array edge, also the matrix dimension
    localparam int N      = 4;
    // signed operand element
    localparam int ELEM_W = 8;
    // accumulator, also the C element written back
    localparam int ACC_W  = 32;
    localparam int AXI_DW = 32;
    localparam int AXI_AW = 32;
    // N rows per operand buffer
    localparam int BUF_AW = 2;

    // feeder run length from start to done
    // last A/B pair reaches PE(N-1,N-1) and is summed before this count
    localparam int FEED_CYCLES = 3 * N + 1;

    typedef logic signed [ELEM_W-1:0] elem_t;
    // element k in byte k
    typedef logic [N*ELEM_W-1:0]      row_t;
    typedef logic signed [ACC_W-1:0]  acc_t;
    // accumulator r*N+c in slice r*N+c
    typedef logic [N*N*ACC_W-1:0]     acc_grid_t;
    typedef logic [AXI_AW-1:0]        axi_addr_t;
    typedef logic [AXI_DW-1:0]        axi_data_t;
    typedef logic [BUF_AW-1:0]        buf_addr_t;

    // job sequence of the DMA engine
    typedef enum logic [2:0] {
        IDLE,
        ADDR_A,
        ADDR_B,
        LOAD,
        WAIT_MM,
        ADDR_C,
        WRITE_C,
        WAIT_B
    } dma_state_t;

endpackage

`default_nettype wire

/* hw/mm_operand_buffer.sv */
// N-row operand store, one write port and one registered read port
// read data shows up the cycle after raddr_i; contents undefined until written
`default_nettype none

module mm_operand_buffer (
    input  wire                       clk,
    // write side, from the DMA engine
    input  wire                       wren_i,
    input  wire mm_pkg::buf_addr_t    waddr_i,
    input  wire mm_pkg::row_t         wdata_i,
    // read side, from the feeder
    input  wire mm_pkg::buf_addr_t    raddr_i,
    output mm_pkg::row_t              rdata_o
);

    // one matrix row per entry
    mm_pkg::row_t mem [mm_pkg::N];

    always_ff @(posedge clk) begin
        if (wren_i)
            mem[waddr_i] <= wdata_i;
    end

    // read every cycle, feeder ignores data outside its window
    always_ff @(posedge clk) begin
        rdata_o <= mem[raddr_i];
    end

endmodule

`default_nettype wire

/* hw/mm_pe.sv */
// output-stationary MAC cell, operands move one hop per cycle right and down
// accumulator wraps at ACC_W bits; zero operands leave it unchanged
`default_nettype none

module mm_pe (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   clear_i,
    input  wire mm_pkg::elem_t    a_i,
    input  wire mm_pkg::elem_t    b_i,
    output mm_pkg::elem_t         a_o,
    output mm_pkg::elem_t         b_o,
    output mm_pkg::acc_t          acc_o
);

    // full signed product
    logic signed [2*mm_pkg::ELEM_W-1:0] prod;

    assign prod = a_i * b_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_o   <= '0;
            b_o   <= '0;
            acc_o <= '0;
        end else begin
            a_o <= a_i;
            b_o <= b_i;
            // clear wins over the product of that cycle
            if (clear_i)
                acc_o <= '0;
            else
                acc_o <= acc_o + prod;
        end
    end

endmodule

`default_nettype wire

/* hw/mm_feeder.sv */
// drives the systolic array edges from the A and B buffers
// A row i is loaded whole then shifted out element by element, B column j is delayed j+1
// done fires FEED_CYCLES after start; edges are zero outside the feed window
`default_nettype none

module mm_feeder (
    input  wire                                        clk,
    input  wire                                        rst_n,
    input  wire                                        start_i,
    output mm_pkg::buf_addr_t                          rd_addr_o,
    input  wire mm_pkg::row_t                          a_row_i,
    input  wire mm_pkg::row_t                          b_row_i,
    output wire [mm_pkg::N*mm_pkg::ELEM_W-1:0]         a_edge_o,
    output wire [mm_pkg::N*mm_pkg::ELEM_W-1:0]         b_edge_o,
    output logic                                       clear_o,
    output logic                                       done_o
);

    // cycles since start, 0 while idle
    logic [$clog2(mm_pkg::FEED_CYCLES+1)-1:0] cnt;
    logic                                     busy;
    // buffer data of row cnt-1 is valid
    logic                                     row_vld;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (start_i) begin
            busy <= 1'b1;
            cnt  <= 1'b1;
        end else if (busy) begin
            if (cnt == mm_pkg::FEED_CYCLES) begin
                busy <= 1'b0;
                cnt  <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // address k in cycle k, row 0 on the start cycle itself
    assign rd_addr_o = mm_pkg::buf_addr_t'(cnt);
    assign row_vld   = busy && (cnt <= mm_pkg::N);
    assign clear_o   = start_i;
    assign done_o    = busy && (cnt == mm_pkg::FEED_CYCLES);

    for (genvar i = 0; i < mm_pkg::N; i++) begin : g_lane
        // row lane i, holds A row i, low byte goes out first
        mm_pkg::row_t  a_sr;
        // column lane i delay line
        mm_pkg::elem_t b_dly [i+1];

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                a_sr  <= '0;
                b_dly <= '{default: '0};
            end else begin
                // row i arrives at cnt i+1, which also gives the skew of i
                if (row_vld && cnt == i + 1)
                    a_sr <= a_row_i;
                else
                    a_sr <= a_sr >> mm_pkg::ELEM_W;
                b_dly[0] <= row_vld ? b_row_i[i*mm_pkg::ELEM_W +: mm_pkg::ELEM_W] : '0;
                for (int d = 1; d <= i; d++)
                    b_dly[d] <= b_dly[d-1];
            end
        end

        // A[i][k] and B[k][j] both enter at cycle k+2 plus lane skew
        assign a_edge_o[i*mm_pkg::ELEM_W +: mm_pkg::ELEM_W] = a_sr[mm_pkg::ELEM_W-1:0];
        assign b_edge_o[i*mm_pkg::ELEM_W +: mm_pkg::ELEM_W] = b_dly[i];
    end

endmodule

`default_nettype wire

/* hw/mm_dma_engine.sv */
// job sequencer: two N-beat AXI reads (A on id 0, B on id 1), array run, 16-beat C write
// one job at a time; start_i outside IDLE is dropped
// config addresses are sampled at start; bresp is taken but not checked
`default_nettype none

module mm_dma_engine (
    input  wire                       clk,
    input  wire                       rst_n,
    // job config
    input  wire mm_pkg::axi_addr_t    mat_a_addr_i,
    input  wire mm_pkg::axi_addr_t    mat_b_addr_i,
    input  wire mm_pkg::axi_addr_t    mat_c_addr_i,
    input  wire                       start_i,
    output logic                      done_o,
    // AR
    output mm_pkg::axi_addr_t         araddr_o,
    output logic                      arid_o,
    output logic [3:0]                arlen_o,
    output logic                      arvalid_o,
    input  wire                       arready_i,
    // R
    input  wire mm_pkg::axi_data_t    rdata_i,
    input  wire                       rid_i,
    input  wire                       rlast_i,
    input  wire                       rvalid_i,
    output logic                      rready_o,
    // AW
    output mm_pkg::axi_addr_t         awaddr_o,
    output logic [7:0]                awlen_o,
    output logic                      awvalid_o,
    input  wire                       awready_i,
    // W
    output mm_pkg::axi_data_t         wdata_o,
    output logic                      wlast_o,
    output logic                      wvalid_o,
    input  wire                       wready_i,
    // B
    input  wire                       bvalid_i,
    input  wire [1:0]                 bresp_i,
    output logic                      bready_o,
    // operand buffer writes
    output logic                      buf_a_wren_o,
    output mm_pkg::buf_addr_t         buf_a_waddr_o,
    output mm_pkg::row_t              buf_a_wdata_o,
    output logic                      buf_b_wren_o,
    output mm_pkg::buf_addr_t         buf_b_waddr_o,
    output mm_pkg::row_t              buf_b_wdata_o,
    // array control
    output logic                      mm_start_o,
    input  wire                       mm_done_i,
    input  wire mm_pkg::acc_grid_t    acc_grid_i
);

    mm_pkg::dma_state_t state;
    mm_pkg::dma_state_t state_nxt;

    // base addresses held for the whole job
    mm_pkg::axi_addr_t a_base;
    mm_pkg::axi_addr_t b_base;
    mm_pkg::axi_addr_t c_base;

    // next buffer row per read id
    mm_pkg::buf_addr_t row_a;
    mm_pkg::buf_addr_t row_b;
    // burst end seen per id
    logic              got_a;
    logic              got_b;

    // C beat index, r*N+c
    logic [$clog2(mm_pkg::N*mm_pkg::N)-1:0] beat;

    logic start_job;
    logic r_hs;
    logic w_hs;
    logic rows_done;
    logic last_beat;

    assign start_job = (state == mm_pkg::IDLE) && start_i;
    assign r_hs      = rvalid_i && rready_o;
    assign w_hs      = wvalid_o && wready_i;
    assign rows_done = got_a && got_b;
    assign last_beat = (beat == mm_pkg::N * mm_pkg::N - 1);

    always_comb begin
        state_nxt = state;
        case (state)
            mm_pkg::IDLE:
                if (start_i)
                    state_nxt = mm_pkg::ADDR_A;
            mm_pkg::ADDR_A:
                if (arready_i)
                    state_nxt = mm_pkg::ADDR_B;
            mm_pkg::ADDR_B:
                if (arready_i)
                    state_nxt = mm_pkg::LOAD;
            // both bursts landed, array start goes out this cycle
            mm_pkg::LOAD:
                if (rows_done)
                    state_nxt = mm_pkg::WAIT_MM;
            mm_pkg::WAIT_MM:
                if (mm_done_i)
                    state_nxt = mm_pkg::ADDR_C;
            mm_pkg::ADDR_C:
                if (awready_i)
                    state_nxt = mm_pkg::WRITE_C;
            mm_pkg::WRITE_C:
                if (wready_i && last_beat)
                    state_nxt = mm_pkg::WAIT_B;
            mm_pkg::WAIT_B:
                if (bvalid_i)
                    state_nxt = mm_pkg::IDLE;
            default:
                state_nxt = mm_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= mm_pkg::IDLE;
            row_a <= '0;
            row_b <= '0;
            got_a <= 1'b0;
            got_b <= 1'b0;
            beat  <= '0;
        end else begin
            state <= state_nxt;
            // counters restart per job
            if (start_job) begin
                row_a <= '0;
                row_b <= '0;
                got_a <= 1'b0;
                got_b <= 1'b0;
                beat  <= '0;
            end
            if (buf_a_wren_o) begin
                row_a <= row_a + 1'b1;
                if (rlast_i)
                    got_a <= 1'b1;
            end
            if (buf_b_wren_o) begin
                row_b <= row_b + 1'b1;
                if (rlast_i)
                    got_b <= 1'b1;
            end
            // wraps back to 0 after beat 15
            if (w_hs)
                beat <= beat + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start_job) begin
            a_base <= mat_a_addr_i;
            b_base <= mat_b_addr_i;
            c_base <= mat_c_addr_i;
        end
    end

    assign done_o     = (state == mm_pkg::IDLE);

    // AR, A first then B
    assign arvalid_o  = (state == mm_pkg::ADDR_A) || (state == mm_pkg::ADDR_B);
    assign arid_o     = (state == mm_pkg::ADDR_B);
    assign araddr_o   = (state == mm_pkg::ADDR_B) ? b_base : a_base;
    assign arlen_o    = 4'(mm_pkg::N - 1);

    // R, stops taking beats once both bursts ended
    assign rready_o   = (state == mm_pkg::LOAD) && !rows_done;

    // rid picks the buffer, the per-id count gives the row
    assign buf_a_wren_o  = r_hs && !rid_i;
    assign buf_a_waddr_o = row_a;
    assign buf_a_wdata_o = rdata_i;
    assign buf_b_wren_o  = r_hs && rid_i;
    assign buf_b_waddr_o = row_b;
    assign buf_b_wdata_o = rdata_i;

    // one cycle after the last buffer write
    assign mm_start_o = (state == mm_pkg::LOAD) && rows_done;

    // AW and W, row-major C
    assign awvalid_o  = (state == mm_pkg::ADDR_C);
    assign awaddr_o   = c_base;
    assign awlen_o    = 8'(mm_pkg::N * mm_pkg::N - 1);
    assign wvalid_o   = (state == mm_pkg::WRITE_C);
    assign wdata_o    = acc_grid_i[beat*mm_pkg::ACC_W +: mm_pkg::ACC_W];
    assign wlast_o    = wvalid_o && last_beat;

    // B, response code not inspected
    assign bready_o   = (state == mm_pkg::WAIT_B);

endmodule

`default_nettype wire

/* hw/mm_top.sv */
// matrix-multiply accelerator top: DMA engine, A/B buffers, feeder, NxN PE grid
// C = A * B for signed 8-bit NxN matrices, results as 32-bit words in row-major order
// fixed AXI settings: 4-byte beats, INCR bursts, all strobes set, write id 0
`default_nettype none

module mm_top (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire mm_pkg::axi_addr_t    mat_a_addr_i,
    input  wire mm_pkg::axi_addr_t    mat_b_addr_i,
    input  wire mm_pkg::axi_addr_t    mat_c_addr_i,
    input  wire                       start_i,
    output logic                      done_o,
    output mm_pkg::axi_addr_t         araddr_o,
    output logic                      arid_o,
    output logic [3:0]                arlen_o,
    output logic                      arvalid_o,
    input  wire                       arready_i,
    input  wire mm_pkg::axi_data_t    rdata_i,
    input  wire                       rid_i,
    input  wire                       rlast_i,
    input  wire                       rvalid_i,
    output logic                      rready_o,
    output mm_pkg::axi_addr_t         awaddr_o,
    output logic [7:0]                awlen_o,
    output logic                      awvalid_o,
    input  wire                       awready_i,
    output mm_pkg::axi_data_t         wdata_o,
    output logic                      wlast_o,
    output logic                      wvalid_o,
    input  wire                       wready_i,
    input  wire                       bvalid_i,
    input  wire [1:0]                 bresp_i,
    output logic                      bready_o
);

    // DMA to buffers
    logic              buf_a_wren;
    logic              buf_b_wren;
    mm_pkg::buf_addr_t buf_a_waddr;
    mm_pkg::buf_addr_t buf_b_waddr;
    mm_pkg::row_t      buf_a_wdata;
    mm_pkg::row_t      buf_b_wdata;

    // feeder side
    mm_pkg::buf_addr_t rd_addr;
    mm_pkg::row_t      a_row;
    mm_pkg::row_t      b_row;
    wire [mm_pkg::N*mm_pkg::ELEM_W-1:0] a_edge;
    wire [mm_pkg::N*mm_pkg::ELEM_W-1:0] b_edge;
    logic              clear;
    logic              mm_start;
    logic              mm_done;
    wire mm_pkg::acc_grid_t acc_grid;

    // PE mesh, column N and row N are the open far edges
    wire mm_pkg::elem_t a_mesh [mm_pkg::N][mm_pkg::N+1];
    wire mm_pkg::elem_t b_mesh [mm_pkg::N+1][mm_pkg::N];

    mm_dma_engine u_dma (
        .clk, .rst_n,
        .mat_a_addr_i, .mat_b_addr_i, .mat_c_addr_i, .start_i, .done_o,
        .araddr_o, .arid_o, .arlen_o, .arvalid_o, .arready_i,
        .rdata_i, .rid_i, .rlast_i, .rvalid_i, .rready_o,
        .awaddr_o, .awlen_o, .awvalid_o, .awready_i,
        .wdata_o, .wlast_o, .wvalid_o, .wready_i,
        .bvalid_i, .bresp_i, .bready_o,
        .buf_a_wren_o  (buf_a_wren),
        .buf_a_waddr_o (buf_a_waddr),
        .buf_a_wdata_o (buf_a_wdata),
        .buf_b_wren_o  (buf_b_wren),
        .buf_b_waddr_o (buf_b_waddr),
        .buf_b_wdata_o (buf_b_wdata),
        .mm_start_o    (mm_start),
        .mm_done_i     (mm_done),
        .acc_grid_i    (acc_grid)
    );

    mm_operand_buffer u_buf_a (
        .clk, .wren_i(buf_a_wren), .waddr_i(buf_a_waddr), .wdata_i(buf_a_wdata),
        .raddr_i(rd_addr), .rdata_o(a_row)
    );

    mm_operand_buffer u_buf_b (
        .clk, .wren_i(buf_b_wren), .waddr_i(buf_b_waddr), .wdata_i(buf_b_wdata),
        .raddr_i(rd_addr), .rdata_o(b_row)
    );

    mm_feeder u_feeder (
        .clk, .rst_n, .start_i(mm_start), .rd_addr_o(rd_addr),
        .a_row_i(a_row), .b_row_i(b_row), .a_edge_o(a_edge), .b_edge_o(b_edge),
        .clear_o(clear), .done_o(mm_done)
    );

    // top edge of the grid
    for (genvar c = 0; c < mm_pkg::N; c++) begin : g_b_edge
        assign b_mesh[0][c] = b_edge[c*mm_pkg::ELEM_W +: mm_pkg::ELEM_W];
    end

    for (genvar r = 0; r < mm_pkg::N; r++) begin : g_row
        // left edge
        assign a_mesh[r][0] = a_edge[r*mm_pkg::ELEM_W +: mm_pkg::ELEM_W];
        for (genvar c = 0; c < mm_pkg::N; c++) begin : g_col
            mm_pe u_pe (
                .clk, .rst_n,
                .clear_i (clear),
                .a_i     (a_mesh[r][c]),
                .b_i     (b_mesh[r][c]),
                .a_o     (a_mesh[r][c+1]),
                .b_o     (b_mesh[r+1][c]),
                .acc_o   (acc_grid[(r*mm_pkg::N+c)*mm_pkg::ACC_W +: mm_pkg::ACC_W])
            );
        end
    end

endmodule

`default_nettype wire

/* tb/mm_clk_gen.sv */
// testbench clock and reset, 40 ns period
// rst_n_o is low for the first 4 rising edges, released 2 ns after the 4th
`default_nettype none

module mm_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    // release clear of the 1 ns drive and sample point
    initial begin
        rst_n_o = 1'b0;
        repeat (4) @(posedge clk_o);
        #2 rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

/* tb/mm_axi_mem.sv */
// AXI slave memory model, 1024 words covering byte addresses 0 to 0xfff
// one outstanding read burst per id and one write burst at a time
// outputs change 1 ns after the rising edge; stall_pct_i runs from 0 to 100
`default_nettype none

module mm_axi_mem (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire [31:0]                stall_pct_i,
    input  wire                       interleave_i,
    input  wire mm_pkg::axi_addr_t    araddr_i,
    input  wire                       arid_i,
    input  wire [3:0]                 arlen_i,
    input  wire                       arvalid_i,
    output logic                      arready_o,
    output mm_pkg::axi_data_t         rdata_o,
    output logic                      rid_o,
    output logic                      rlast_o,
    output logic                      rvalid_o,
    input  wire                       rready_i,
    input  wire mm_pkg::axi_addr_t    awaddr_i,
    input  wire [7:0]                 awlen_i,
    input  wire                       awvalid_i,
    output logic                      awready_o,
    input  wire mm_pkg::axi_data_t    wdata_i,
    input  wire                       wlast_i,
    input  wire                       wvalid_i,
    output logic                      wready_o,
    output logic                      bvalid_o,
    output logic [1:0]                bresp_o,
    input  wire                       bready_i,
    // transfer counters, never cleared
    output int                        aw_cnt_o,
    output int                        w_beats_o,
    output int                        wlast_err_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] mem [0:1023];

    // read burst state per id
    logic rd_act  [0:1];
    int   rd_word [0:1];
    int   rd_left [0:1];
    logic last_id;
    // write burst state
    logic w_act;
    int   w_word;
    int   w_len;
    int   w_idx;
    logic b_pend;

    // true when this cycle is not stalled
    function automatic logic no_stall();
        return ($urandom % 100) >= stall_pct_i;
    endfunction

    initial begin
        arready_o   = 1'b0;
        rvalid_o    = 1'b0;
        rdata_o     = '0;
        rid_o       = 1'b0;
        rlast_o     = 1'b0;
        awready_o   = 1'b0;
        wready_o    = 1'b0;
        bvalid_o    = 1'b0;
        bresp_o     = 2'b00;
        aw_cnt_o    = 0;
        w_beats_o   = 0;
        wlast_err_o = 0;
        rd_act[0]   = 1'b0;
        rd_act[1]   = 1'b0;
        rd_word[0]  = 0;
        rd_word[1]  = 0;
        last_id     = 1'b1;
        w_act       = 1'b0;
        b_pend      = 1'b0;
    end

    always @(posedge clk) begin : model
        logic ar_hs;
        logic r_hs;
        logic aw_hs;
        logic w_hs;
        logic b_hs;
        logic sel;
        // handshakes as seen on this edge
        ar_hs = arvalid_i && arready_o;
        r_hs  = rvalid_o && rready_i;
        aw_hs = awvalid_i && awready_o;
        w_hs  = wvalid_i && wready_o;
        b_hs  = bvalid_o && bready_i;
        if (!rst_n) begin
            rd_act[0] = 1'b0;
            rd_act[1] = 1'b0;
            last_id   = 1'b1;
            w_act     = 1'b0;
            b_pend    = 1'b0;
        end else begin
            if (ar_hs) begin
                rd_act[arid_i]  = 1'b1;
                rd_word[arid_i] = int'(araddr_i[11:2]);
                rd_left[arid_i] = arlen_i + 1;
            end
            if (r_hs) begin
                rd_word[rid_o] = rd_word[rid_o] + 1;
                rd_left[rid_o] = rd_left[rid_o] - 1;
                if (rd_left[rid_o] == 0)
                    rd_act[rid_o] = 1'b0;
                last_id = rid_o;
            end
            if (aw_hs) begin
                w_act    = 1'b1;
                w_word   = int'(awaddr_i[11:2]);
                w_len    = awlen_i;
                w_idx    = 0;
                aw_cnt_o = aw_cnt_o + 1;
            end
            if (w_hs) begin
                mem[(w_word + w_idx) % 1024] = wdata_i;
                w_beats_o = w_beats_o + 1;
                // wlast must sit on the final beat only
                if (wlast_i != (w_idx == w_len))
                    wlast_err_o = wlast_err_o + 1;
                if (w_idx == w_len) begin
                    w_act  = 1'b0;
                    b_pend = 1'b1;
                end
                w_idx = w_idx + 1;
            end
            if (b_hs)
                b_pend = 1'b0;
        end
        #1;
        if (!rst_n) begin
            arready_o = 1'b0;
            rvalid_o  = 1'b0;
            awready_o = 1'b0;
            wready_o  = 1'b0;
            bvalid_o  = 1'b0;
        end else begin
            arready_o = no_stall();
            awready_o = !w_act && !b_pend && no_stall();
            wready_o  = w_act && no_stall();
            // bvalid holds once raised
            bvalid_o  = b_pend && (bvalid_o || no_stall());
            // a pending R beat keeps its payload
            if (!(rvalid_o && !r_hs)) begin
                if (rd_act[0] && rd_act[1])
                    sel = interleave_i ? !last_id : 1'b0;
                else
                    sel = rd_act[1];
                rvalid_o = (rd_act[0] || rd_act[1]) && no_stall();
                rid_o    = sel;
                rdata_o  = mem[rd_word[sel] % 1024];
                rlast_o  = (rd_left[sel] == 1);
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tb_mm_top.sv */
// testbench for mm_top, a table of jobs run back to back without reset
// C is checked against the signed sum of products, plus guard words and untouched A/B
// memory model adds random stalls and interleaved read bursts per job
`default_nettype none

module tb_mm_top;
    timeunit 1ns;
    timeprecision 1ps;

    // 16 elements, element r*N+k in byte r*N+k
    typedef logic [mm_pkg::N*mm_pkg::N*mm_pkg::ELEM_W-1:0] mat_t;

    typedef struct packed {
        mat_t        a;
        mat_t        b;
        logic        rnd;
        logic [31:0] a_addr;
        logic [31:0] b_addr;
        logic [31:0] c_addr;
        logic [31:0] stall;
        logic        ilv;
        logic        dbl;
    } job_t;

    wire                     clk;
    wire                     rst_n;
    logic                    start;
    mm_pkg::axi_addr_t       mat_a_addr;
    mm_pkg::axi_addr_t       mat_b_addr;
    mm_pkg::axi_addr_t       mat_c_addr;
    wire                     done;
    wire mm_pkg::axi_addr_t  araddr;
    wire                     arid;
    wire [3:0]               arlen;
    wire                     arvalid;
    wire                     arready;
    wire mm_pkg::axi_data_t  rdata;
    wire                     rid;
    wire                     rlast;
    wire                     rvalid;
    wire                     rready;
    wire mm_pkg::axi_addr_t  awaddr;
    wire [7:0]               awlen;
    wire                     awvalid;
    wire                     awready;
    wire mm_pkg::axi_data_t  wdata;
    wire                     wlast;
    wire                     wvalid;
    wire                     wready;
    wire                     bvalid;
    wire [1:0]               bresp;
    wire                     bready;
    logic [31:0]             stall_pct;
    logic                    interleave;
    wire [31:0]              aw_cnt;
    wire [31:0]              w_beats;
    wire [31:0]              wlast_err;

    job_t jobs [0:6];
    int   n_checks;
    int   n_errors;

    mm_clk_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

    mm_top uut (
        .clk, .rst_n,
        .mat_a_addr_i(mat_a_addr), .mat_b_addr_i(mat_b_addr), .mat_c_addr_i(mat_c_addr),
        .start_i(start), .done_o(done),
        .araddr_o(araddr), .arid_o(arid), .arlen_o(arlen), .arvalid_o(arvalid),
        .arready_i(arready),
        .rdata_i(rdata), .rid_i(rid), .rlast_i(rlast), .rvalid_i(rvalid), .rready_o(rready),
        .awaddr_o(awaddr), .awlen_o(awlen), .awvalid_o(awvalid), .awready_i(awready),
        .wdata_o(wdata), .wlast_o(wlast), .wvalid_o(wvalid), .wready_i(wready),
        .bvalid_i(bvalid), .bresp_i(bresp), .bready_o(bready)
    );

    mm_axi_mem u_mem (
        .clk, .rst_n, .stall_pct_i(stall_pct), .interleave_i(interleave),
        .araddr_i(araddr), .arid_i(arid), .arlen_i(arlen), .arvalid_i(arvalid),
        .arready_o(arready),
        .rdata_o(rdata), .rid_o(rid), .rlast_o(rlast), .rvalid_o(rvalid), .rready_i(rready),
        .awaddr_i(awaddr), .awlen_i(awlen), .awvalid_i(awvalid), .awready_o(awready),
        .wdata_i(wdata), .wlast_i(wlast), .wvalid_i(wvalid), .wready_o(wready),
        .bvalid_o(bvalid), .bresp_o(bresp), .bready_i(bready),
        .aw_cnt_o(aw_cnt), .w_beats_o(w_beats), .wlast_err_o(wlast_err)
    );

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    // C[r][c] as the signed sum over k of A[r][k]*B[k][c]
    function automatic int golden(input mat_t a, input mat_t b, input int r, input int c);
        int sum;
        int av;
        int bv;
        sum = 0;
        for (int k = 0; k < mm_pkg::N; k++) begin
            av  = $signed(a[(r*mm_pkg::N+k)*8 +: 8]);
            bv  = $signed(b[(k*mm_pkg::N+c)*8 +: 8]);
            sum = sum + av * bv;
        end
        return sum;
    endfunction

    // odd multiplier, so every address bit shows in the word
    function automatic logic [31:0] fill_word(input int w);
        return (w * 32'h9e37_79b9) ^ 32'h0bad_f00d;
    endfunction

    function automatic mat_t rand_matrix();
        mat_t m;
        for (int w = 0; w < mm_pkg::N; w++)
            m[w*32 +: 32] = $urandom;
        // both extremes always present
        m[7:0]     = 8'h80;
        m[15:8]    = 8'h7f;
        m[127:120] = 8'h80;
        return m;
    endfunction

    function automatic job_t make_job(input mat_t a, input mat_t b, input logic rnd,
                                      input int aa, input int ba, input int ca,
                                      input int stall, input logic ilv, input logic dbl);
        job_t j;
        j.a      = a;
        j.b      = b;
        j.rnd    = rnd;
        j.a_addr = aa;
        j.b_addr = ba;
        j.c_addr = ca;
        j.stall  = stall;
        j.ilv    = ilv;
        j.dbl    = dbl;
        return j;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < 20) begin
            next_cycle();
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("timeout: reset was never released");
            $display("Simulation FAILED");
            $finish;
        end
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (done !== 1'b1 && n < 4000) begin
            next_cycle();
            n++;
        end
        if (done !== 1'b1) begin
            $display("timeout: done_o still low after %0d cycles", n);
            $display("Simulation FAILED");
            $finish;
        end
    endtask

    task automatic preload(input job_t j);
        for (int w = 0; w < 1024; w++)
            u_mem.mem[w] = fill_word(w);
        for (int w = 0; w < mm_pkg::N; w++) begin
            u_mem.mem[(j.a_addr >> 2) + w] = j.a[w*32 +: 32];
            u_mem.mem[(j.b_addr >> 2) + w] = j.b[w*32 +: 32];
        end
    endtask

    task automatic run_job(input job_t j);
        int aw0;
        int wb0;
        int we0;
        int cw;
        preload(j);
        aw0        = aw_cnt;
        wb0        = w_beats;
        we0        = wlast_err;
        stall_pct  = j.stall;
        interleave = j.ilv;
        mat_a_addr = j.a_addr;
        mat_b_addr = j.b_addr;
        mat_c_addr = j.c_addr;
        start      = 1'b1;
        next_cycle();
        start      = 1'b0;
        compare("done_o after start", done, 1'b0);
        compare("arvalid after start", arvalid, 1'b1);
        // second start mid-job, must be dropped
        if (j.dbl) begin
            repeat (3) next_cycle();
            mat_a_addr = 32'hd00;
            mat_b_addr = 32'hd40;
            mat_c_addr = 32'he00;
            start      = 1'b1;
            next_cycle();
            start      = 1'b0;
        end
        wait_done();
        repeat (3) begin
            next_cycle();
            compare("done_o stays high", done, 1'b1);
            compare("arvalid while idle", arvalid, 1'b0);
        end
        compare("AW bursts per job", aw_cnt - aw0, 1);
        compare("W beats per job", w_beats - wb0, mm_pkg::N * mm_pkg::N);
        compare("misplaced wlast", wlast_err - we0, 0);
        cw = j.c_addr >> 2;
        for (int r = 0; r < mm_pkg::N; r++)
            for (int c = 0; c < mm_pkg::N; c++)
                compare("C word", u_mem.mem[cw + r*mm_pkg::N + c], golden(j.a, j.b, r, c));
        // 4 guard words on each side of C
        for (int k = 1; k <= 4; k++) begin
            compare("guard below C", u_mem.mem[cw - k], fill_word(cw - k));
            compare("guard above C", u_mem.mem[cw + 15 + k], fill_word(cw + 15 + k));
        end
        for (int k = 0; k < mm_pkg::N; k++) begin
            compare("A word", u_mem.mem[(j.a_addr >> 2) + k], j.a[k*32 +: 32]);
            compare("B word", u_mem.mem[(j.b_addr >> 2) + k], j.b[k*32 +: 32]);
        end
    endtask

    initial begin : main
        job_t j;
        mat_t ident;
        mat_t b_pat;
        mat_t ext_a;
        mat_t ext_b;
        void'($urandom(32'heac34f01));
        start      = 1'b0;
        mat_a_addr = '0;
        mat_b_addr = '0;
        mat_c_addr = '0;
        stall_pct  = 0;
        interleave = 1'b0;
        n_checks   = 0;
        n_errors   = 0;
        ident = {32'h0100_0000, 32'h0001_0000, 32'h0000_0100, 32'h0000_0001};
        b_pat = {32'h7f80_0c81, 32'hf3e2_d1c0, 32'h0403_0201, 32'h807f_1e2d};
        ext_a = {8{8'h80, 8'h7f}};
        ext_b = {4{8'h80, 8'h80, 8'h7f, 8'h81}};
        // a, b, rnd, A addr, B addr, C addr, stall %, interleave, extra start
        jobs[0] = make_job(ident, b_pat, 1'b0, 'h000, 'h040, 'h100, 0, 1'b0, 1'b0);
        jobs[1] = make_job('0, '0, 1'b1, 'h200, 'h300, 'h400, 0, 1'b0, 1'b0);
        jobs[2] = make_job(ext_a, ext_b, 1'b0, 'h080, 'h0c0, 'h180, 0, 1'b0, 1'b0);
        jobs[3] = make_job(ext_a, ext_b, 1'b0, 'h500, 'h520, 'h600, 40, 1'b0, 1'b0);
        jobs[4] = make_job('0, '0, 1'b1, 'h700, 'h710, 'h800, 40, 1'b1, 1'b0);
        jobs[5] = make_job('0, '0, 1'b1, 'h900, 'ha00, 'hb00, 0, 1'b1, 1'b1);
        jobs[6] = make_job('0, '0, 1'b1, 'hf00, 'hf40, 'hf80, 60, 1'b1, 1'b1);

        wait_reset();
        compare("done_o after reset", done, 1'b1);
        compare("arvalid after reset", arvalid, 1'b0);
        compare("awvalid after reset", awvalid, 1'b0);
        compare("wvalid after reset", wvalid, 1'b0);
        compare("array start after reset", uut.mm_start, 1'b0);

        for (int i = 0; i < 7; i++) begin
            j = jobs[i];
            if (j.rnd) begin
                j.a = rand_matrix();
                j.b = rand_matrix();
            end
            run_job(j);
        end

        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
hw/mm_pkg.sv
hw/mm_operand_buffer.sv
hw/mm_pe.sv
hw/mm_feeder.sv
hw/mm_dma_engine.sv
hw/mm_top.sv
tb/mm_clk_gen.sv
tb/mm_axi_mem.sv
tb/tb_mm_top.sv
